//--- design/text_map_pkg.sv
package text_map_pkg;

    // ----------------------------------------
    // address map
    // ----------------------------------------

    // byte address seen on the AXI bus
    localparam int AXI_ADDR_W = 14;

    // high address bit picks the region, 1 selects the palette
    localparam int REGION_BIT = 13;

    // word index starts above the byte offset
    localparam int ADDR_LSB = 2;

    // ----------------------------------------
    // region sizes
    // ----------------------------------------

    // number of colour registers in the palette file
    localparam int PAL_DEPTH = 8;
    localparam int PAL_IDX_W = $clog2(PAL_DEPTH);

    // vram word address spans the bits between the byte offset and the region bit
    localparam int VRAM_AW = REGION_BIT - ADDR_LSB;

    // one palette entry
    localparam int COLOR_W = 32;

    // ----------------------------------------
    // types
    // ----------------------------------------

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [VRAM_AW-1:0]    vram_addr_t;
    typedef logic [PAL_IDX_W-1:0]  pal_index_t;
    typedef logic [COLOR_W-1:0]    color_t;

endpackage

//--- design/axi_lite_pkg.sv
package axi_lite_pkg;

    // ----------------------------------------
    // bus widths
    // ----------------------------------------

    localparam int AXI_DATA_W = 32;
    // one strobe bit per byte lane
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [1:0]            axi_resp_t;

    // only response this slave ever returns
    localparam axi_resp_t RESP_OKAY = 2'b00;

    // ----------------------------------------
    // read timing
    // ----------------------------------------

    // cycles the controller waits before presenting read data
    localparam int READ_WAIT = 3;
    localparam int WAIT_W    = $clog2(READ_WAIT + 1);

    // control fsm, one transaction at a time
    typedef enum logic [1:0] {
        st_idle,
        st_wr_resp,
        st_rd_wait,
        st_rd_resp
    } ctrl_state_t;

endpackage

//--- design/reg_access_if.sv
`timescale 1ns/1ns

interface reg_access_if
    import text_map_pkg::*, axi_lite_pkg::*;
();

    // one-cycle access strobes, exactly one per accepted transaction
    logic      vram_sel;
    logic      pal_sel;
    // high for a write access, valid together with a strobe
    logic      write;
    axi_addr_t addr;
    axi_data_t wdata;
    axi_strb_t wstrb;

    // read-back from the two regions
    axi_data_t vram_rdata;
    axi_data_t pal_rdata;

    // control side, decodes the region and raises the strobes
    modport ctrl (
        output vram_sel, pal_sel, write, addr, wdata, wstrb,
        input  vram_rdata, pal_rdata
    );

    // block ram side
    modport vram (
        input  vram_sel, write, addr, wdata, wstrb,
        output vram_rdata
    );

    // colour register side, vram_sel only feeds the exclusivity check
    modport palette (
        input  pal_sel, vram_sel, write, addr, wdata, wstrb,
        output pal_rdata
    );

endinterface

//--- design/axi_slave_ctrl.sv
`timescale 1ns/1ns

module axi_slave_ctrl
    import text_map_pkg::*, axi_lite_pkg::*;
(
    input  logic      S_AXI_ACLK,
    input  logic      S_AXI_ARESETN,
    // write address and data
    input  axi_addr_t s_axi_awaddr,
    input  logic      s_axi_awvalid,
    output logic      s_axi_awready,
    input  axi_data_t s_axi_wdata,
    input  axi_strb_t s_axi_wstrb,
    input  logic      s_axi_wvalid,
    output logic      s_axi_wready,
    // write response
    output logic      s_axi_bvalid,
    input  logic      s_axi_bready,
    // read address and data
    input  axi_addr_t s_axi_araddr,
    input  logic      s_axi_arvalid,
    output logic      s_axi_arready,
    output axi_data_t s_axi_rdata,
    output logic      s_axi_rvalid,
    input  logic      s_axi_rready,
    // register and vram access
    reg_access_if.ctrl bus
);

    ctrl_state_t       state;
    axi_addr_t         addr_q;
    logic [WAIT_W-1:0] wait_cnt;

    logic idle_free;
    logic rd_accept;
    logic wr_accept;
    logic rd_done;
    logic access;

    // ----------------------------------------
    // acceptance decode
    // ----------------------------------------

    // idle and no handshake already in flight
    assign idle_free = (state == st_idle) && !s_axi_arready && !s_axi_awready;
    // read wins when both arrive together
    assign rd_accept = idle_free && s_axi_arvalid;
    assign wr_accept = idle_free && !s_axi_arvalid && s_axi_awvalid && s_axi_wvalid;
    // last wait cycle, read-back of either region is settled
    assign rd_done   = (state == st_rd_wait) && (wait_cnt == '0);

    // ----------------------------------------
    // control fsm
    // ----------------------------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            state         <= st_idle;
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_arready <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            wait_cnt      <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (s_axi_arready)
                    begin
                        // AR handshake ends on this edge, start the wait
                        s_axi_arready <= 1'b0;
                        wait_cnt      <= WAIT_W'(READ_WAIT);
                        state         <= st_rd_wait;
                    end
                    else if (s_axi_awready)
                    begin
                        // AW and W handshake together, response follows
                        s_axi_awready <= 1'b0;
                        s_axi_wready  <= 1'b0;
                        s_axi_bvalid  <= 1'b1;
                        state         <= st_wr_resp;
                    end
                    else if (rd_accept)
                    begin
                        s_axi_arready <= 1'b1;
                    end
                    else if (wr_accept)
                    begin
                        s_axi_awready <= 1'b1;
                        s_axi_wready  <= 1'b1;
                    end
                end
                st_wr_resp:
                begin
                    // hold the response until the master takes it
                    if (s_axi_bready)
                    begin
                        s_axi_bvalid <= 1'b0;
                        state        <= st_idle;
                    end
                end
                st_rd_wait:
                begin
                    if (wait_cnt == '0)
                    begin
                        s_axi_rvalid <= 1'b1;
                        state        <= st_rd_resp;
                    end
                    else
                    begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                st_rd_resp:
                begin
                    if (s_axi_rready)
                    begin
                        s_axi_rvalid <= 1'b0;
                        state        <= st_idle;
                    end
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ----------------------------------------
    // address latch and read data
    // ----------------------------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (rd_accept)
        begin
            addr_q <= s_axi_araddr;
        end
        else if (wr_accept)
        begin
            addr_q <= s_axi_awaddr;
        end
        // latched region bit picks the read-back source
        if (rd_done)
        begin
            s_axi_rdata <= addr_q[REGION_BIT] ? bus.pal_rdata : bus.vram_rdata;
        end
    end

    // strobe lives exactly in the ready cycle
    assign access       = s_axi_arready | s_axi_awready;
    assign bus.vram_sel = access & ~addr_q[REGION_BIT];
    assign bus.pal_sel  = access & addr_q[REGION_BIT];
    assign bus.write    = s_axi_awready;
    assign bus.addr     = addr_q;
    // master holds W stable until the handshake
    assign bus.wdata    = s_axi_wdata;
    assign bus.wstrb    = s_axi_wstrb;

    // ----------------------------------------
    // checks
    // ----------------------------------------

    // transactions are serialized, never both address channels at once
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_awready && s_axi_arready));

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

    // read data must not move while the master stalls
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

//--- design/vram_port.sv
`timescale 1ns/1ns

module vram_port
    import text_map_pkg::*, axi_lite_pkg::*;
(
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,
    reg_access_if.vram bus,
    // single-port block ram
    output logic       enable,
    output axi_strb_t  write_enable,
    output vram_addr_t ram_addr,
    output axi_data_t  ram_wdata,
    input  axi_data_t  ram_rdata
);

    vram_addr_t word_addr;

    // drop the byte offset and the region bit
    assign word_addr = bus.addr[REGION_BIT-1:ADDR_LSB];

    // ----------------------------------------
    // ram port control
    // ----------------------------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            enable       <= 1'b0;
            write_enable <= '0;
        end
        else if (bus.vram_sel)
        begin
            enable <= 1'b1;
            // reads leave every byte lane disabled
            write_enable <= bus.write ? bus.wstrb : '0;
        end
    end

    // address and data hold until the next vram access
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (bus.vram_sel)
        begin
            ram_addr  <= word_addr;
            ram_wdata <= bus.wdata;
        end
    end

    // ----------------------------------------
    // read-back
    // ----------------------------------------

    // ram answers one cycle after the port, one more stage here
    always_ff @(posedge S_AXI_ACLK)
    begin
        bus.vram_rdata <= ram_rdata;
    end

    // byte writes only happen on an enabled port
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (write_enable != '0) |-> enable);

endmodule

//--- design/palette_regs.sv
`timescale 1ns/1ns

module palette_regs
    import text_map_pkg::*, axi_lite_pkg::*;
(
    input  logic          S_AXI_ACLK,
    input  logic          S_AXI_ARESETN,
    reg_access_if.palette bus,
    // lookup ports for the display logic
    input  pal_index_t    foreground_index,
    input  pal_index_t    background_index,
    output color_t        foreground,
    output color_t        background
);

    color_t     pal_q [PAL_DEPTH];
    pal_index_t bus_idx;

    // word index within the palette region
    assign bus_idx = bus.addr[ADDR_LSB +: PAL_IDX_W];

    // ----------------------------------------
    // bus writes
    // ----------------------------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            for (int i = 0; i < PAL_DEPTH; i++)
            begin
                pal_q[i] <= '0;
            end
        end
        else if (bus.pal_sel && bus.write)
        begin
            // only lanes with their strobe set are updated
            for (int b = 0; b < AXI_STRB_W; b++)
            begin
                if (bus.wstrb[b])
                begin
                    pal_q[bus_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // bus read-back and colour lookups, all combinational
    assign bus.pal_rdata = pal_q[bus_idx];
    assign foreground    = pal_q[foreground_index];
    assign background    = pal_q[background_index];

    // the region decode upstream must pick one target only
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(bus.pal_sel && bus.vram_sel));

endmodule

//--- design/text_ctrl_axi.sv
`timescale 1ns/1ns

module text_ctrl_axi
    import text_map_pkg::*, axi_lite_pkg::*;
(
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,
    // write channels
    input  axi_addr_t  s_axi_awaddr,
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,
    input  axi_data_t  s_axi_wdata,
    input  axi_strb_t  s_axi_wstrb,
    input  logic       s_axi_wvalid,
    output logic       s_axi_wready,
    output axi_resp_t  s_axi_bresp,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,
    // read channels
    input  axi_addr_t  s_axi_araddr,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,
    output axi_data_t  s_axi_rdata,
    output axi_resp_t  s_axi_rresp,
    output logic       s_axi_rvalid,
    input  logic       s_axi_rready,
    // vram block ram port
    output logic       enable,
    output axi_strb_t  write_enable,
    output vram_addr_t ram_addr,
    output axi_data_t  ram_wdata,
    input  axi_data_t  ram_rdata,
    // palette lookups
    input  pal_index_t foreground_index,
    input  pal_index_t background_index,
    output color_t     foreground,
    output color_t     background
);

    reg_access_if bus ();

    // no error responses in this design
    assign s_axi_bresp = RESP_OKAY;
    assign s_axi_rresp = RESP_OKAY;

    // ----------------------------------------
    // axi control
    // ----------------------------------------

    axi_slave_ctrl i_ctrl (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .bus           (bus)
    );

    // ----------------------------------------
    // datapaths
    // ----------------------------------------

    vram_port i_vram (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .bus           (bus),
        .enable        (enable),
        .write_enable  (write_enable),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata),
        .ram_rdata     (ram_rdata)
    );

    palette_regs i_palette (
        .S_AXI_ACLK       (S_AXI_ACLK),
        .S_AXI_ARESETN    (S_AXI_ARESETN),
        .bus              (bus),
        .foreground_index (foreground_index),
        .background_index (background_index),
        .foreground       (foreground),
        .background       (background)
    );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk   = 1'b0;
        rst_n = 1'b0;
        // hold reset for the given number of rising edges
        repeat (RESET_CYCLES) @(posedge clk);
        // release on a falling edge like the rest of the stimulus
        @(negedge clk);
        rst_n = 1'b1;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- sim/tb_vram_model.sv
`timescale 1ns/1ns

module tb_vram_model
    import text_map_pkg::*, axi_lite_pkg::*;
(
    input  logic       clk,
    input  logic       enable,
    input  axi_strb_t  write_enable,
    input  vram_addr_t addr,
    input  axi_data_t  wdata,
    output axi_data_t  rdata
);

    localparam int WORDS = 1 << VRAM_AW;

    axi_data_t mem [WORDS];
    axi_data_t rd_q = '0;

    // preload, every word differs with its full address
    initial
    begin
        for (int i = 0; i < WORDS; i++)
        begin
            mem[i] = (axi_data_t'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
        end
    end

    // read-first single port, data one cycle after the address
    always @(posedge clk)
    begin
        if (enable)
        begin
            rd_q <= mem[addr];
            for (int b = 0; b < AXI_STRB_W; b++)
            begin
                if (write_enable[b])
                begin
                    mem[addr][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
    end

    assign rdata = rd_q;

endmodule

//--- sim/tb_text_ctrl.sv
`timescale 1ns/1ns

module tb_text_ctrl
    import text_map_pkg::*, axi_lite_pkg::*;
();

    // ----------------------------------------
    // run limits
    // ----------------------------------------

    localparam int NUM_TRANS      = 200;
    // worst transaction incl. response delay and lookup check, plus margin
    localparam int TIMEOUT_CYCLES = NUM_TRANS * 20 + 1000;
    // rising edges from the AR handshake to RVALID
    localparam int RD_LATENCY     = 4;
    localparam int VRAM_WORDS     = 1 << VRAM_AW;

    logic       clk;
    logic       rst_n;
    axi_addr_t  awaddr;
    logic       awvalid;
    logic       awready;
    axi_data_t  wdata;
    axi_strb_t  wstrb;
    logic       wvalid;
    logic       wready;
    axi_resp_t  bresp;
    logic       bvalid;
    logic       bready;
    axi_addr_t  araddr;
    logic       arvalid;
    logic       arready;
    axi_data_t  rdata;
    axi_resp_t  rresp;
    logic       rvalid;
    logic       rready;
    logic       enable;
    axi_strb_t  write_enable;
    vram_addr_t ram_addr;
    axi_data_t  ram_wdata;
    axi_data_t  ram_rdata;
    pal_index_t foreground_index;
    pal_index_t background_index;
    color_t     foreground;
    color_t     background;

    integer seed = 47;
    int     data_errs;
    int     resp_errs;
    int     color_errs;
    int     proto_errs;
    int     cycles;

    // reference model state
    axi_data_t vram_shadow [VRAM_WORDS];
    color_t    pal_shadow  [PAL_DEPTH];

    // ram port snapshot while a palette write runs
    logic      pal_wr_busy;
    axi_data_t ctrl_snap;
    axi_data_t wdata_snap;

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(8)) i_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tb_vram_model i_ram (
        .clk          (clk),
        .enable       (enable),
        .write_enable (write_enable),
        .addr         (ram_addr),
        .wdata        (ram_wdata),
        .rdata        (ram_rdata)
    );

    text_ctrl_axi i_dut (
        .S_AXI_ACLK       (clk),
        .S_AXI_ARESETN    (rst_n),
        .s_axi_awaddr     (awaddr),
        .s_axi_awvalid    (awvalid),
        .s_axi_awready    (awready),
        .s_axi_wdata      (wdata),
        .s_axi_wstrb      (wstrb),
        .s_axi_wvalid     (wvalid),
        .s_axi_wready     (wready),
        .s_axi_bresp      (bresp),
        .s_axi_bvalid     (bvalid),
        .s_axi_bready     (bready),
        .s_axi_araddr     (araddr),
        .s_axi_arvalid    (arvalid),
        .s_axi_arready    (arready),
        .s_axi_rdata      (rdata),
        .s_axi_rresp      (rresp),
        .s_axi_rvalid     (rvalid),
        .s_axi_rready     (rready),
        .enable           (enable),
        .write_enable     (write_enable),
        .ram_addr         (ram_addr),
        .ram_wdata        (ram_wdata),
        .ram_rdata        (ram_rdata),
        .foreground_index (foreground_index),
        .background_index (background_index),
        .foreground       (foreground),
        .background       (background)
    );

    // ----------------------------------------
    // checks
    // ----------------------------------------

    task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
        if (got !== exp)
        begin
            data_errs++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        if (got !== exp)
        begin
            resp_errs++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        if (got !== exp)
        begin
            color_errs++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_fault(input string msg);
        proto_errs++;
        $display("%s", msg);
    endtask

    // no address handshake may start while a response is owed
    task automatic check_no_accept(input string phase);
        if (awready || arready)
        begin
            report_fault({"address accepted while a ", phase, " response was pending"});
        end
    endtask

    // another request waits on both address channels during a pending response
    task automatic drive_competing_valids(input logic on);
        awvalid = on;
        wvalid  = on;
        arvalid = on;
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic axi_data_t vram_fill(input int unsigned word);
        return (axi_data_t'(word) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    function automatic axi_data_t apply_strobe(input axi_data_t old_word,
                                               input axi_data_t new_word,
                                               input axi_strb_t strb);
        axi_data_t res;
        res = old_word;
        for (int b = 0; b < AXI_STRB_W; b++)
        begin
            if (strb[b])
            begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic axi_data_t expected_read(input axi_addr_t addr);
        axi_data_t res;
        // region bit 1 selects the palette
        if (addr[REGION_BIT])
        begin
            res = pal_shadow[addr[ADDR_LSB +: PAL_IDX_W]];
        end
        else
        begin
            res = vram_shadow[addr[REGION_BIT-1:ADDR_LSB]];
        end
        return res;
    endfunction

    // enable, byte enables and word address packed for one compare
    function automatic axi_data_t port_ctrl_word();
        return {16'h0000, enable, write_enable, ram_addr};
    endfunction

    // ----------------------------------------
    // bus transactions
    // ----------------------------------------

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
        int delay;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready)
        begin
            @(negedge clk);
        end
        if (!wready)
        begin
            report_fault("awready rose without wready");
        end
        // the rising edge in between ends the handshake
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (awready || wready)
        begin
            report_fault("write ready stayed high for more than one cycle");
        end
        drive_competing_valids(1'b1);
        delay = $unsigned($random(seed)) % 5;
        repeat (delay)
        begin
            if (!bvalid)
            begin
                report_fault("bvalid low while the write response was owed");
            end
            check_no_accept("write");
            @(negedge clk);
        end
        // withdrawn before the response edge returns the fsm to idle
        drive_competing_valids(1'b0);
        if (!bvalid)
        begin
            report_fault("bvalid low when bready was raised");
        end
        check_resp("bresp", bresp, RESP_OKAY);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        if (bvalid)
        begin
            report_fault("bvalid still high after the response was taken");
        end
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
        int delay;
        int lat;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready)
        begin
            @(negedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        drive_competing_valids(1'b1);
        // count rising edges since the AR handshake
        lat = 0;
        while (!rvalid && lat <= RD_LATENCY + 4)
        begin
            check_no_accept("read");
            @(negedge clk);
            lat++;
        end
        if (lat != RD_LATENCY)
        begin
            report_fault($sformatf("rvalid rose %0d edges after the address handshake", lat));
        end
        data = rdata;
        delay = $unsigned($random(seed)) % 5;
        repeat (delay)
        begin
            if (!rvalid)
            begin
                report_fault("rvalid dropped before rready");
            end
            check_data("rdata held", rdata, data);
            check_no_accept("read");
            @(negedge clk);
        end
        drive_competing_valids(1'b0);
        check_resp("rresp", rresp, RESP_OKAY);
        check_data("rdata held", rdata, data);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        if (rvalid)
        begin
            report_fault("rvalid still high after the read data was taken");
        end
    endtask

    // new random indices, colours compared one cycle later
    task automatic check_lookups();
        pal_index_t fi;
        pal_index_t bi;
        fi = pal_index_t'($random(seed));
        bi = pal_index_t'($random(seed));
        foreground_index = fi;
        background_index = bi;
        @(negedge clk);
        check_color("foreground", foreground, pal_shadow[fi]);
        check_color("background", background, pal_shadow[bi]);
    endtask

    // ----------------------------------------
    // monitors
    // ----------------------------------------

    // ram port must stay frozen across palette writes
    always @(negedge clk)
    begin
        if (pal_wr_busy)
        begin
            check_data("ram port control", port_ctrl_word(), ctrl_snap);
            check_data("ram_wdata", ram_wdata, wdata_snap);
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    initial
    begin
        int        kind;
        logic      to_pal;
        axi_addr_t addr;
        axi_data_t data;
        axi_strb_t strb;
        axi_data_t rd;
        color_t    fg_snap;
        color_t    bg_snap;

        awaddr           = '0;
        awvalid          = 1'b0;
        wdata            = '0;
        wstrb            = '0;
        wvalid           = 1'b0;
        bready           = 1'b0;
        araddr           = '0;
        arvalid          = 1'b0;
        rready           = 1'b0;
        foreground_index = '0;
        background_index = '0;
        pal_wr_busy      = 1'b0;
        ctrl_snap        = '0;
        wdata_snap       = '0;
        data_errs        = 0;
        resp_errs        = 0;
        color_errs       = 0;
        proto_errs       = 0;
        cycles           = 0;
        for (int i = 0; i < VRAM_WORDS; i++)
        begin
            vram_shadow[i] = vram_fill(i);
        end
        for (int i = 0; i < PAL_DEPTH; i++)
        begin
            pal_shadow[i] = '0;
        end

        wait (rst_n);
        @(negedge clk);
        if (awready || wready || arready || bvalid || rvalid || enable || write_enable != '0)
        begin
            report_fault("a ready, valid or ram enable output is high after reset");
        end
        // palette starts cleared at every index
        for (int i = 0; i < PAL_DEPTH; i++)
        begin
            foreground_index = pal_index_t'(i);
            background_index = pal_index_t'(PAL_DEPTH - 1 - i);
            @(negedge clk);
            check_color("foreground", foreground, pal_shadow[i]);
            check_color("background", background, pal_shadow[PAL_DEPTH - 1 - i]);
        end

        for (int n = 0; n < NUM_TRANS; n++)
        begin
            kind   = $unsigned($random(seed)) % 4;
            to_pal = (kind >= 2);
            addr   = axi_addr_t'($random(seed));
            addr[REGION_BIT] = to_pal;
            // narrow vram window so reads often hit written words
            if (!to_pal)
            begin
                addr[9:4] = '0;
            end
            if (kind % 2 == 0)
            begin
                data = $random(seed);
                strb = axi_strb_t'($random(seed));
                fg_snap = foreground;
                bg_snap = background;
                if (to_pal)
                begin
                    ctrl_snap   = port_ctrl_word();
                    wdata_snap  = ram_wdata;
                    pal_wr_busy = 1'b1;
                end
                axi_write(addr, data, strb);
                pal_wr_busy = 1'b0;
                if (to_pal)
                begin
                    pal_shadow[addr[ADDR_LSB +: PAL_IDX_W]] =
                        apply_strobe(pal_shadow[addr[ADDR_LSB +: PAL_IDX_W]], data, strb);
                end
                else
                begin
                    vram_shadow[addr[REGION_BIT-1:ADDR_LSB]] =
                        apply_strobe(vram_shadow[addr[REGION_BIT-1:ADDR_LSB]], data, strb);
                    // vram traffic leaves the colour lookups alone
                    check_color("foreground", foreground, fg_snap);
                    check_color("background", background, bg_snap);
                end
            end
            else
            begin
                axi_read(addr, rd);
                check_data("rdata", rd, expected_read(addr));
            end
            check_lookups();
        end

        $display("errors: data %0d, resp %0d, color %0d, protocol %0d",
                 data_errs, resp_errs, color_errs, proto_errs);
        if (data_errs + resp_errs + color_errs + proto_errs == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- build.f
design/text_map_pkg.sv
design/axi_lite_pkg.sv
design/reg_access_if.sv
design/axi_slave_ctrl.sv
design/vram_port.sv
design/palette_regs.sv
design/text_ctrl_axi.sv
sim/tb_clock_gen.sv
sim/tb_vram_model.sv
sim/tb_text_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator, result taken from the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_text_ctrl \
    -f build.f \
    -o tb_text_ctrl

./obj_dir/tb_text_ctrl > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    exit 1
fi
if ! grep -q "all tests passed" "$LOG"; then
    exit 1
fi
